/* source/ecfg_config.svh */
// elink config slave constants
`ifndef ECFG_CONFIG_SVH
`define ECFG_CONFIG_SVH

// chip id, compared against dstaddr[31:20]
`define ECFG_ID 12'h800

// mesh packet width
`define ECFG_PW 104

// mesh address width
`define ECFG_AW 32

// data width, 32-bit accesses only
`define ECFG_DW 32

// register bus address, the low half of the mesh address
`define ECFG_MI_AW 16

// mailbox entries, power of two
`define ECFG_MBOX_DEPTH 4

// read-only version word
`define ECFG_VERSION 32'h0102_0003

`endif

/* source/emesh_pkg.sv */
// emesh packet and register map types
`default_nettype none

`include "ecfg_config.svh"

package emesh_pkg;

  // block select codes, dstaddr[19:16]
  localparam logic [3:0] BLK_BASE = 4'd0;
  localparam logic [3:0] BLK_MBOX = 4'd1;

  // base block word indices
  localparam logic [3:0] REG_RESET   = 4'd0;
  localparam logic [3:0] REG_CLK     = 4'd1;
  localparam logic [3:0] REG_VERSION = 4'd2;
  localparam logic [3:0] REG_SCRATCH = 4'd3;

  // mailbox word indices
  localparam logic [3:0] MBOX_DATA = 4'd0;
  localparam logic [3:0] MBOX_STAT = 4'd1;

  // mesh address, raw word or split into chip / block / byte offset
  typedef union packed {
    logic [`ECFG_AW-1:0] word;
    struct packed {
      logic [11:0]            chip_id;
      logic [3:0]             blk;
      // word index lives in bits 5:2
      logic [`ECFG_MI_AW-1:0] offset;
    } fields;
  } emesh_addr_u;

  // 104-bit mesh packet, msb first
  typedef struct packed {
    logic [`ECFG_AW-1:0] srcaddr;
    logic [`ECFG_DW-1:0] data;
    emesh_addr_u         dstaddr;
    logic [4:0]          ctrlmode;
    logic [1:0]          datamode;
    logic                write;
  } emesh_packet_t;

endpackage

`default_nettype wire

/* source/mi_if.sv */
// register bus interface
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

interface mi_if;

  // one-cycle access strobe
  logic                   en;
  // write qualifier for en
  logic                   we;
  // byte offset within the block
  logic [`ECFG_MI_AW-1:0] addr;
  // write data
  logic [`ECFG_DW-1:0]    din;
  // read data, valid the cycle after a read strobe
  logic [`ECFG_DW-1:0]    dout;

  // request side, the config interface
  modport master (
    output en,
    output we,
    output addr,
    output din,
    input  dout
  );

  // register block side
  modport slave (
    input  en,
    input  we,
    input  addr,
    input  din,
    output dout
  );

endinterface

`default_nettype wire

/* source/ecfg_base_regs.sv */
// base configuration registers
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

module ecfg_base_regs (
  input  logic       txwr_clk,
  input  logic       rst_n,
  mi_if.slave        mi,
  output logic       soft_reset,
  output logic [3:0] clk_div
);

  import emesh_pkg::*;

  logic [3:0]          idx;
  logic                wr;
  logic                rd;
  logic [`ECFG_DW-1:0] reset_reg;
  logic [`ECFG_DW-1:0] clk_reg;
  logic [`ECFG_DW-1:0] scratch_reg;
  logic [`ECFG_DW-1:0] rd_val;

  // word index from the byte offset
  assign idx = mi.addr[5:2];
  assign wr  = mi.en & mi.we;
  assign rd  = mi.en & ~mi.we;

  // writable registers
  always_ff @(posedge txwr_clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_reg   <= '0;
      clk_reg     <= '0;
      scratch_reg <= '0;
    end else if (wr) begin
      case (idx)
        REG_RESET:   reset_reg   <= mi.din;
        REG_CLK:     clk_reg     <= mi.din;
        REG_SCRATCH: scratch_reg <= mi.din;
        // version and holes drop the write
        default: ;
      endcase
    end
  end

  // readback select
  always_comb begin
    case (idx)
      REG_RESET:   rd_val = reset_reg;
      REG_CLK:     rd_val = clk_reg;
      REG_VERSION: rd_val = `ECFG_VERSION;
      REG_SCRATCH: rd_val = scratch_reg;
      default:     rd_val = '0;
    endcase
  end

  // dout held until the next read
  always_ff @(posedge txwr_clk) begin
    if (rd) begin
      mi.dout <= rd_val;
    end
  end

  // control outputs
  assign soft_reset = reset_reg[0];
  assign clk_div    = clk_reg[3:0];

endmodule

`default_nettype wire

/* source/ecfg_mailbox.sv */
// receive mailbox fifo
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

module ecfg_mailbox (
  input  logic txwr_clk,
  input  logic rst_n,
  mi_if.slave  mi,
  output logic mbox_not_empty
);

  import emesh_pkg::*;

  localparam int DEPTH = `ECFG_MBOX_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  // zero fill between overflow bit and count
  localparam int PAD_W = `ECFG_DW - PTR_W - 2;

  logic [`ECFG_DW-1:0] mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [PTR_W:0]      count;
  logic                ovf;
  logic [3:0]          idx;
  logic                push;
  logic                pop;
  logic                stat_rd;
  logic                full;
  logic                empty;

  assign idx     = mi.addr[5:2];
  assign push    = mi.en & mi.we & (idx == MBOX_DATA);
  assign pop     = mi.en & ~mi.we & (idx == MBOX_DATA);
  assign stat_rd = mi.en & ~mi.we & (idx == MBOX_STAT);
  assign full    = (count == DEPTH[PTR_W:0]);
  assign empty   = (count == '0);

  // pointers, count, sticky overflow
  // push and pop never share a cycle, one strobe per access
  always_ff @(posedge txwr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
        count  <= count + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
        count  <= count - 1'b1;
      end
      // full push is dropped and flagged
      if (push && full) begin
        ovf <= 1'b1;
      end else if (stat_rd) begin
        ovf <= 1'b0;
      end
    end
  end

  // storage and registered read data
  always_ff @(posedge txwr_clk) begin
    if (push && !full) begin
      mem[wr_ptr] <= mi.din;
    end
    if (pop) begin
      mi.dout <= empty ? '0 : mem[rd_ptr];
    end else if (stat_rd) begin
      mi.dout <= {ovf, {PAD_W{1'b0}}, count};
    end else if (mi.en && !mi.we) begin
      mi.dout <= '0;
    end
  end

  assign mbox_not_empty = ~empty;

endmodule

`default_nettype wire

/* source/ecfg_if.sv */
// elink configuration interface
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

module ecfg_if (
  input  logic                     txwr_clk,
  input  logic                     rst_n,
  input  logic                     txwr_access,
  input  emesh_pkg::emesh_packet_t txwr_packet,
  input  logic                     txrd_access,
  input  emesh_pkg::emesh_packet_t txrd_packet,
  output logic                     rxrr_access,
  output emesh_pkg::emesh_packet_t rxrr_packet,
  mi_if.master                     mi_base,
  mi_if.master                     mi_mbox
);

  import emesh_pkg::*;

  // decoded request addresses
  emesh_addr_u         wr_dst;
  emesh_addr_u         rd_dst;
  emesh_addr_u         req_dst;
  logic                wr_hit;
  logic                rd_hit;
  logic                rd_take;
  logic                req_any;

  // bus request registers, shared by both blocks except en
  logic                en_base_q;
  logic                en_mbox_q;
  logic                we_q;
  logic [`ECFG_MI_AW-1:0] addr_q;
  logic [`ECFG_DW-1:0] din_q;

  // read pipe, stage 1 lines up with en
  logic                rd_q1;
  logic [`ECFG_AW-1:0] rd_src_q1;
  emesh_addr_u         rd_dst_q1;

  // stage 2 lines up with block dout
  logic [`ECFG_AW-1:0] rsp_src_q2;
  emesh_addr_u         rsp_dst_q2;
  logic [3:0]          rsp_blk_q2;
  logic [`ECFG_DW-1:0] rsp_data;

  assign wr_dst = txwr_packet.dstaddr;
  assign rd_dst = txrd_packet.dstaddr;

  // only requests carrying our chip id
  assign wr_hit  = txwr_access & (wr_dst.fields.chip_id == `ECFG_ID);
  assign rd_hit  = txrd_access & (rd_dst.fields.chip_id == `ECFG_ID);
  // write wins, a colliding read is lost
  assign rd_take = rd_hit & ~wr_hit;
  assign req_any = wr_hit | rd_hit;
  assign req_dst = wr_hit ? wr_dst : rd_dst;

  // strobe and qualifiers, one cycle after the request
  always_ff @(posedge txwr_clk or negedge rst_n) begin
    if (!rst_n) begin
      en_base_q <= 1'b0;
      en_mbox_q <= 1'b0;
      we_q      <= 1'b0;
      rd_q1     <= 1'b0;
      rxrr_access <= 1'b0;
    end else begin
      en_base_q <= req_any & (req_dst.fields.blk == BLK_BASE);
      en_mbox_q <= req_any & (req_dst.fields.blk == BLK_MBOX);
      we_q      <= wr_hit;
      // unknown blocks still get a response
      rd_q1     <= rd_take;
      rxrr_access <= rd_q1;
    end
  end

  // bus payload and read return addresses
  always_ff @(posedge txwr_clk) begin
    addr_q     <= req_dst.fields.offset;
    din_q      <= txwr_packet.data;
    rd_src_q1  <= txrd_packet.srcaddr;
    rd_dst_q1  <= rd_dst;
    rsp_src_q2 <= rd_src_q1;
    rsp_dst_q2 <= rd_dst_q1;
    rsp_blk_q2 <= rd_dst_q1.fields.blk;
  end

  assign mi_base.en   = en_base_q;
  assign mi_base.we   = we_q;
  assign mi_base.addr = addr_q;
  assign mi_base.din  = din_q;
  assign mi_mbox.en   = en_mbox_q;
  assign mi_mbox.we   = we_q;
  assign mi_mbox.addr = addr_q;
  assign mi_mbox.din  = din_q;

  // steer registered dout back by the delayed block select
  always_comb begin
    case (rsp_blk_q2)
      BLK_BASE: rsp_data = mi_base.dout;
      BLK_MBOX: rsp_data = mi_mbox.dout;
      default:  rsp_data = '0;
    endcase
  end

  // read response, addresses swapped
  always_comb begin
    rxrr_packet              = '0;
    rxrr_packet.write        = 1'b1;
    rxrr_packet.dstaddr.word = rsp_src_q2;
    rxrr_packet.srcaddr      = rsp_dst_q2.word;
    rxrr_packet.data         = rsp_data;
  end

endmodule

`default_nettype wire

/* source/ecfg_top.sv */
// elink config slave top
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

module ecfg_top (
  input  logic               txwr_clk,
  input  logic               rst_n,
  // host write requests
  input  logic               txwr_access,
  input  logic [`ECFG_PW-1:0] txwr_packet,
  // host read requests
  input  logic               txrd_access,
  input  logic [`ECFG_PW-1:0] txrd_packet,
  // read responses
  output logic               rxrr_access,
  output logic [`ECFG_PW-1:0] rxrr_packet,
  // base block controls
  output logic               soft_reset,
  output logic [3:0]         clk_div,
  // mailbox status
  output logic               mbox_not_empty
);

  import emesh_pkg::*;

  emesh_packet_t wr_pkt;
  emesh_packet_t rd_pkt;
  emesh_packet_t rr_pkt;

  // flat vectors to packet view
  assign wr_pkt      = emesh_packet_t'(txwr_packet);
  assign rd_pkt      = emesh_packet_t'(txrd_packet);
  assign rxrr_packet = rr_pkt;

  // one register bus per block
  mi_if mi_base ();
  mi_if mi_mbox ();

  ecfg_if u_ecfg_if (
    .txwr_clk    (txwr_clk),
    .rst_n       (rst_n),
    .txwr_access (txwr_access),
    .txwr_packet (wr_pkt),
    .txrd_access (txrd_access),
    .txrd_packet (rd_pkt),
    .rxrr_access (rxrr_access),
    .rxrr_packet (rr_pkt),
    .mi_base     (mi_base.master),
    .mi_mbox     (mi_mbox.master)
  );

  ecfg_base_regs u_base_regs (
    .txwr_clk   (txwr_clk),
    .rst_n      (rst_n),
    .mi         (mi_base.slave),
    .soft_reset (soft_reset),
    .clk_div    (clk_div)
  );

  ecfg_mailbox u_mailbox (
    .txwr_clk       (txwr_clk),
    .rst_n          (rst_n),
    .mi             (mi_mbox.slave),
    .mbox_not_empty (mbox_not_empty)
  );

endmodule

`default_nettype wire

/* verification/ecfg_asserts.sv */
// config interface protocol checks
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

module ecfg_asserts (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     wr_access,
  input emesh_pkg::emesh_packet_t wr_packet,
  input logic                     rd_access,
  input emesh_pkg::emesh_packet_t rd_packet,
  input logic                     rxrr_access,
  input logic                     en_base,
  input logic                     en_mbox
);

  // failures so far, read by the testbench at the end
  int   fail_cnt;
  logic wr_hit;
  logic rd_hit;
  logic rd_ok;

  initial fail_cnt = 0;

  // chip id match, independent of the dut decode
  assign wr_hit = wr_access && (wr_packet.dstaddr.fields.chip_id == `ECFG_ID);
  assign rd_hit = rd_access && (rd_packet.dstaddr.fields.chip_id == `ECFG_ID);
  // a colliding write wins
  assign rd_ok  = rd_hit && !wr_hit;

  // accepted read answers two cycles on
  read_gets_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    rd_ok |-> ##2 rxrr_access)
    else begin
      $error("accepted read without response two cycles later");
      fail_cnt = fail_cnt + 1;
    end

  // no response without a read behind it
  rsp_has_read: assert property (@(posedge clk) disable iff (!rst_n)
    rxrr_access |-> $past(rd_ok, 2))
    else begin
      $error("response with no accepted read two cycles earlier");
      fail_cnt = fail_cnt + 1;
    end

  // strobes only for our own chip id
  en_own_chip: assert property (@(posedge clk) disable iff (!rst_n)
    (en_base || en_mbox) |-> $past(wr_hit || rd_hit))
    else begin
      $error("block strobe after a request for a foreign chip");
      fail_cnt = fail_cnt + 1;
    end

  // one block at a time
  en_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(en_base && en_mbox))
    else begin
      $error("both block strobes high in one cycle");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind ecfg_if ecfg_asserts u_asserts (
  .clk         (txwr_clk),
  .rst_n       (rst_n),
  .wr_access   (txwr_access),
  .wr_packet   (txwr_packet),
  .rd_access   (txrd_access),
  .rd_packet   (txrd_packet),
  .rxrr_access (rxrr_access),
  .en_base     (en_base_q),
  .en_mbox     (en_mbox_q)
);

`default_nettype wire

/* verification/ecfg_tb.sv */
// config slave testbench
`timescale 1ns/10ps
`default_nettype none

`include "ecfg_config.svh"

module ecfg_tb;

  import emesh_pkg::*;

  // cycles allowed for outstanding responses
  localparam int RSP_TIMEOUT = 16;

  logic                txwr_clk;
  logic                rst_n;
  logic                txwr_access;
  logic [`ECFG_PW-1:0] txwr_packet;
  logic                txrd_access;
  logic [`ECFG_PW-1:0] txrd_packet;
  logic                rxrr_access;
  logic [`ECFG_PW-1:0] rxrr_packet;
  logic                soft_reset;
  logic [3:0]          clk_div;
  logic                mbox_not_empty;

  // register map model
  logic [31:0]   base_m [4];
  logic [31:0]   fifo_m [$];
  logic          ovf_m;
  // predicted and seen responses, oldest first
  emesh_packet_t exp_q [$];
  emesh_packet_t rsp_q [$];
  logic [31:0]   rng;
  int            errors;
  int            timeouts;

  ecfg_top u_ecfg_top (
    .txwr_clk       (txwr_clk),
    .rst_n          (rst_n),
    .txwr_access    (txwr_access),
    .txwr_packet    (txwr_packet),
    .txrd_access    (txrd_access),
    .txrd_packet    (txrd_packet),
    .rxrr_access    (rxrr_access),
    .rxrr_packet    (rxrr_packet),
    .soft_reset     (soft_reset),
    .clk_div        (clk_div),
    .mbox_not_empty (mbox_not_empty)
  );

  always #50 txwr_clk = ~txwr_clk;

  // responses taken mid-cycle
  always @(negedge txwr_clk) begin
    if (rst_n && rxrr_access) begin
      rsp_q.push_back(emesh_packet_t'(rxrr_packet));
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic roll(output logic [31:0] r);
    rng = xorshift32(rng);
    r = rng;
  endtask

  // request packet, union split view for the address
  function automatic emesh_packet_t make_pkt(input logic [11:0] chip, input logic [3:0] blk,
                                             input logic [3:0] idx);
    emesh_addr_u   a;
    emesh_packet_t p;
    a.word           = '0;
    a.fields.chip_id = chip;
    a.fields.blk     = blk;
    a.fields.offset  = {10'd0, idx, 2'b00};
    p         = '0;
    p.dstaddr = a;
    return p;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic apply_write(input logic [3:0] blk, input logic [3:0] idx, input logic [31:0] d);
    if (blk == BLK_BASE && idx < 4'd4 && idx != REG_VERSION) begin
      base_m[idx[1:0]] = d;
    end else if (blk == BLK_MBOX && idx == MBOX_DATA) begin
      // full fifo drops the word and flags it
      if (fifo_m.size() < `ECFG_MBOX_DEPTH) begin
        fifo_m.push_back(d);
      end else begin
        ovf_m = 1'b1;
      end
    end
  endtask

  task automatic predict_read(input logic [3:0] blk, input logic [3:0] idx,
                              output logic [31:0] v);
    v = '0;
    if (blk == BLK_BASE) begin
      if (idx == REG_VERSION) begin
        v = `ECFG_VERSION;
      end else if (idx < 4'd4) begin
        v = base_m[idx[1:0]];
      end
    end else if (blk == BLK_MBOX) begin
      if (idx == MBOX_DATA && fifo_m.size() > 0) begin
        v = fifo_m.pop_front();
      end else if (idx == MBOX_STAT) begin
        // count low, overflow on top, cleared by this read
        v     = fifo_m.size();
        v[31] = ovf_m;
        ovf_m = 1'b0;
      end
    end
  endtask

  task automatic write_req(input logic [3:0] blk, input logic [3:0] idx,
                           input logic [31:0] d, input logic [11:0] chip);
    emesh_packet_t p;
    p           = make_pkt(chip, blk, idx);
    p.data      = d;
    p.write     = 1'b1;
    txwr_packet = p;
    txwr_access = 1'b1;
    if (chip == `ECFG_ID) begin
      apply_write(blk, idx, d);
    end
    @(posedge txwr_clk);
    #1;
    txwr_access = 1'b0;
  endtask

  task automatic read_req(input logic [3:0] blk, input logic [3:0] idx, input logic [11:0] chip);
    emesh_packet_t p;
    emesh_packet_t e;
    logic [31:0]   r;
    logic [31:0]   v;
    roll(r);
    p           = make_pkt(chip, blk, idx);
    p.srcaddr   = r;
    txrd_packet = p;
    txrd_access = 1'b1;
    if (chip == `ECFG_ID) begin
      predict_read(blk, idx, v);
      // response swaps the two addresses
      e              = '0;
      e.write        = 1'b1;
      e.dstaddr.word = p.srcaddr;
      e.srcaddr      = p.dstaddr.word;
      e.data         = v;
      exp_q.push_back(e);
    end
    @(posedge txwr_clk);
    #1;
    txrd_access = 1'b0;
  endtask

  // write and read in one cycle, read is lost
  task automatic collide_req(input logic [3:0] idx, input logic [31:0] d);
    emesh_packet_t p;
    p           = make_pkt(`ECFG_ID, BLK_BASE, idx);
    p.data      = d;
    p.write     = 1'b1;
    txwr_packet = p;
    txrd_packet = make_pkt(`ECFG_ID, BLK_BASE, idx);
    txwr_access = 1'b1;
    txrd_access = 1'b1;
    apply_write(BLK_BASE, idx, d);
    @(posedge txwr_clk);
    #1;
    txwr_access = 1'b0;
    txrd_access = 1'b0;
  endtask

  task automatic drain(input string name);
    emesh_packet_t e;
    emesh_packet_t a;
    int            n;
    n = 0;
    while (rsp_q.size() < exp_q.size() && n < RSP_TIMEOUT) begin
      @(posedge txwr_clk);
      #1;
      n++;
    end
    if (rsp_q.size() < exp_q.size()) begin
      timeouts++;
      $display("%s: timed out waiting for %0d responses", name, exp_q.size() - rsp_q.size());
    end
    // idle cycles to catch stray responses
    repeat (3) begin
      @(posedge txwr_clk);
      #1;
    end
    while (exp_q.size() > 0 && rsp_q.size() > 0) begin
      e = exp_q.pop_front();
      a = rsp_q.pop_front();
      check_val({name, " data"}, e.data, a.data);
      check_val({name, " dstaddr"}, e.dstaddr.word, a.dstaddr.word);
      check_val({name, " srcaddr"}, e.srcaddr, a.srcaddr);
      check_val({name, " ctrl bits"}, {24'd0, e.ctrlmode, e.datamode, e.write},
                {24'd0, a.ctrlmode, a.datamode, a.write});
    end
    assert (rsp_q.size() == 0) else begin
      errors++;
      $display("%s: %0d responses arrived with no read behind them", name, rsp_q.size());
    end
    exp_q.delete();
    rsp_q.delete();
  endtask

  // outputs settle one edge after the last write
  task automatic check_ctrl(input string name);
    @(posedge txwr_clk);
    #1;
    check_val({name, " soft_reset"}, {31'd0, base_m[0][0]}, {31'd0, soft_reset});
    check_val({name, " clk_div"}, {28'd0, base_m[1][3:0]}, {28'd0, clk_div});
    check_val({name, " mbox_not_empty"}, {31'd0, fifo_m.size() != 0}, {31'd0, mbox_not_empty});
  endtask

  initial begin
    int          k;
    logic [31:0] d;
    logic [3:0]  idx;
    logic [11:0] chip;
    txwr_clk    = 1'b0;
    rst_n       = 1'b0;
    txwr_access = 1'b0;
    txrd_access = 1'b0;
    txwr_packet = '0;
    txrd_packet = '0;
    rng         = 32'h0d67_bcde;
    errors      = 0;
    timeouts    = 0;
    ovf_m       = 1'b0;
    foreach (base_m[i]) begin
      base_m[i] = '0;
    end
    repeat (2) @(posedge txwr_clk);
    #1;
    rst_n = 1'b1;

    // state right out of reset
    check_val("reset rxrr_access", 32'd0, {31'd0, rxrr_access});
    check_ctrl("reset");

    // random writes, readback and control outputs
    for (k = 0; k < 9; k++) begin
      idx = (k % 3 == 0) ? REG_SCRATCH : ((k % 3 == 1) ? REG_RESET : REG_CLK);
      roll(d);
      write_req(BLK_BASE, idx, d, `ECFG_ID);
      check_ctrl("base write");
      read_req(BLK_BASE, idx, `ECFG_ID);
      drain("base readback");
    end

    // version is read only
    read_req(BLK_BASE, REG_VERSION, `ECFG_ID);
    roll(d);
    write_req(BLK_BASE, REG_VERSION, d, `ECFG_ID);
    read_req(BLK_BASE, REG_VERSION, `ECFG_ID);
    drain("version");

    // back to back reads, holes and unknown block read zero
    read_req(BLK_BASE, REG_SCRATCH, `ECFG_ID);
    read_req(BLK_BASE, REG_RESET, `ECFG_ID);
    read_req(4'h7, REG_RESET, `ECFG_ID);
    read_req(BLK_BASE, REG_CLK, `ECFG_ID);
    read_req(BLK_BASE, 4'd9, `ECFG_ID);
    read_req(BLK_MBOX, MBOX_STAT, `ECFG_ID);
    drain("back to back reads");

    // foreign chip id is ignored
    roll(d);
    chip = d[31:20];
    if (chip == `ECFG_ID) begin
      chip = ~chip;
    end
    write_req(BLK_BASE, REG_SCRATCH, d, chip);
    write_req(BLK_MBOX, MBOX_DATA, d, chip);
    read_req(BLK_BASE, REG_SCRATCH, chip);
    drain("foreign chip");
    read_req(BLK_BASE, REG_SCRATCH, `ECFG_ID);
    read_req(BLK_MBOX, MBOX_STAT, `ECFG_ID);
    drain("after foreign chip");

    // collision keeps the write only
    roll(d);
    collide_req(REG_SCRATCH, d);
    drain("collision");
    read_req(BLK_BASE, REG_SCRATCH, `ECFG_ID);
    drain("after collision");

    // mailbox order and empty pop
    for (k = 0; k < 3; k++) begin
      roll(d);
      write_req(BLK_MBOX, MBOX_DATA, d, `ECFG_ID);
    end
    check_ctrl("mailbox push");
    read_req(BLK_MBOX, MBOX_STAT, `ECFG_ID);
    for (k = 0; k < 4; k++) begin
      read_req(BLK_MBOX, MBOX_DATA, `ECFG_ID);
    end
    drain("mailbox order");
    check_ctrl("mailbox drained");

    // overflow is sticky until a status read
    for (k = 0; k < `ECFG_MBOX_DEPTH + 2; k++) begin
      roll(d);
      write_req(BLK_MBOX, MBOX_DATA, d, `ECFG_ID);
    end
    check_ctrl("mailbox full");
    read_req(BLK_MBOX, MBOX_STAT, `ECFG_ID);
    read_req(BLK_MBOX, MBOX_STAT, `ECFG_ID);
    drain("mailbox overflow");
    for (k = 0; k < `ECFG_MBOX_DEPTH; k++) begin
      read_req(BLK_MBOX, MBOX_DATA, `ECFG_ID);
    end
    drain("mailbox flush");
    check_ctrl("mailbox empty");

    $display("errors: %0d value, %0d timeout, %0d assertion", errors, timeouts,
             u_ecfg_top.u_ecfg_if.u_asserts.fail_cnt);
    if (errors == 0 && timeouts == 0 && u_ecfg_top.u_ecfg_if.u_asserts.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/emesh_pkg.sv
source/mi_if.sv
source/ecfg_base_regs.sv
source/ecfg_mailbox.sv
source/ecfg_if.sv
source/ecfg_top.sv
verification/ecfg_asserts.sv
verification/ecfg_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the config slave testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ecfg_tb -f compile.f -o ecfg_sim

# keep running past assertion errors so the testbench prints its summary
./obj_dir/ecfg_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  exit 1
fi
